// ==== snd_pkg.sv ====
/* Sound board shared types and tables */

`default_nettype none

package snd_pkg;

    // Widths with a meaning on the board
    typedef logic [14:0]        rom_addr_t;  // 32 KB ADPCM ROM
    typedef logic [7:0]         rom_byte_t;
    typedef logic [3:0]         nibble_t;    // One ADPCM code
    typedef logic signed [11:0] pcm_t;       // Decoder output
    typedef logic signed [15:0] snd_t;       // Mixed audio
    typedef logic [5:0]         step_idx_t;  // 0..48

    // Command sequencer
    typedef enum logic [2:0] {
        S_IDLE,  // Waiting for a command
        S_REQ,   // req high, waiting for ack
        S_DROP,  // req low, waiting for ack to fall
        S_HI,    // High nibble due on next tick
        S_LO     // Low nibble due on next tick
    } seq_state_t;

    // Sample rate divider
    localparam int ADPCM_DIV = 32;
    localparam int DIV_W     = $clog2(ADPCM_DIV);

    localparam int SAMPLE_BYTES = 256;  // One command plays this many bytes

    localparam int IDX_MAX = 48;  // Last entry of the step table

    // OKI step sizes
    localparam logic [10:0] STEP_TABLE [0:IDX_MAX] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // Index change per code magnitude
    localparam logic signed [4:0] INDEX_ADJ [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

    // 12-bit PCM limits
    localparam int PCM_MAX = 2047;
    localparam int PCM_MIN = -2048;

endpackage

`default_nettype wire

// ==== adpcm_rom_if.sv ====
/* ADPCM ROM handshake bus */

`timescale 1ns/1ps
`default_nettype none

interface adpcm_rom_if;

    logic                req;   // Held until ack rises
    logic                ack;   // Data valid while high
    snd_pkg::rom_addr_t  addr;  // Stable while req is high
    snd_pkg::rom_byte_t  data;

    // Sequencer side
    modport master (
        output req,
        output addr,
        input  ack,
        input  data
    );

    // Pin side at the top level
    modport slave (
        input  req,
        input  addr,
        output ack,
        output data
    );

endinterface

`default_nettype wire

// ==== adpcm_rate_timer.sv ====
/* ADPCM sample rate strobe */

`timescale 1ns/1ps
`default_nettype none

module adpcm_rate_timer (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam logic [snd_pkg::DIV_W-1:0] LAST = snd_pkg::DIV_W'(snd_pkg::ADPCM_DIV - 1);

    logic [snd_pkg::DIV_W-1:0] cnt;

    // Free running, one strobe per period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Last count of the period
    assign tick = (cnt == LAST);

endmodule

`default_nettype wire

// ==== adpcm_seq_fsm.sv ====
/* ADPCM command sequencer */

`timescale 1ns/1ps
`default_nettype none

module adpcm_seq_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_wr,
    input  snd_pkg::rom_byte_t  cmd,
    input  logic                tick,
    adpcm_rom_if.master         rom,
    output snd_pkg::nibble_t    nib,
    output logic                nib_valid,
    output logic                clear,
    output logic                busy
);

    localparam logic [7:0] LAST_BYTE = 8'(snd_pkg::SAMPLE_BYTES - 1);

    snd_pkg::seq_state_t state;
    snd_pkg::rom_addr_t  addr;
    snd_pkg::rom_byte_t  data;  // Byte being played
    logic [7:0]          cnt;   // Bytes done in this sample
    logic                req;

    assign rom.req  = req;
    assign rom.addr = addr;
    assign busy     = (state != snd_pkg::S_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= snd_pkg::S_IDLE;
            addr      <= '0;
            cnt       <= '0;
            req       <= 1'b0;
            nib_valid <= 1'b0;
            clear     <= 1'b0;
        end else begin
            nib_valid <= 1'b0;  // Single cycle strobes
            clear     <= 1'b0;
            case (state)
                snd_pkg::S_IDLE: begin
                    if (cmd_wr) begin
                        // Sample base is cmd * 256 wrapped to the ROM size
                        addr  <= snd_pkg::rom_addr_t'({cmd, 8'h00});
                        cnt   <= '0;
                        req   <= 1'b1;
                        clear <= 1'b1;  // Fresh decoder state
                        state <= snd_pkg::S_REQ;
                    end
                end
                snd_pkg::S_REQ: begin
                    if (rom.ack) begin
                        req   <= 1'b0;
                        state <= snd_pkg::S_DROP;
                    end
                end
                snd_pkg::S_DROP: begin
                    // Wait ack low before any new req
                    if (!rom.ack) state <= snd_pkg::S_HI;
                end
                snd_pkg::S_HI: begin
                    if (tick) begin
                        nib_valid <= 1'b1;
                        state     <= snd_pkg::S_LO;
                    end
                end
                snd_pkg::S_LO: begin
                    if (tick) begin
                        nib_valid <= 1'b1;
                        if (cnt == LAST_BYTE) begin
                            state <= snd_pkg::S_IDLE;  // Sample done
                        end else begin
                            cnt   <= cnt + 1'b1;
                            addr  <= addr + 1'b1;
                            req   <= 1'b1;
                            state <= snd_pkg::S_REQ;
                        end
                    end
                end
                default: state <= snd_pkg::S_IDLE;
            endcase
        end
    end

    // Byte capture on ack and nibble select on tick
    always_ff @(posedge clk) begin
        if (state == snd_pkg::S_REQ && rom.ack) data <= rom.data;
        if (tick) begin
            if (state == snd_pkg::S_HI) nib <= data[7:4];  // High first
            if (state == snd_pkg::S_LO) nib <= data[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== adpcm_decoder.sv ====
/* OKI ADPCM decoder */

`timescale 1ns/1ps
`default_nettype none

module adpcm_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  snd_pkg::nibble_t  nib,
    input  logic              nib_valid,
    output snd_pkg::pcm_t     pcm,
    output logic              pcm_valid
);

    snd_pkg::pcm_t      signal;  // Running PCM value
    snd_pkg::step_idx_t idx;
    snd_pkg::pcm_t      signal_nx;
    snd_pkg::step_idx_t idx_nx;

    logic [10:0]        step;
    logic [12:0]        diff;     // Up to 1.875 * 1552
    logic signed [13:0] delta;
    logic signed [13:0] sum;
    logic signed [4:0]  adj;
    logic signed [7:0]  idx_sum;

    always_comb begin
        step = snd_pkg::STEP_TABLE[idx];

        // Magnitude from the three low code bits
        diff = 13'(step >> 3);
        if (nib[0]) diff = diff + 13'(step >> 2);
        if (nib[1]) diff = diff + 13'(step >> 1);
        if (nib[2]) diff = diff + 13'(step);

        // Sign bit
        delta = nib[3] ? -$signed({1'b0, diff}) : $signed({1'b0, diff});
        sum   = $signed({{2{signal[11]}}, signal}) + delta;

        // Clamp to 12 bits
        if (sum > 14'(snd_pkg::PCM_MAX)) begin
            signal_nx = 12'(snd_pkg::PCM_MAX);
        end else if (sum < 14'(snd_pkg::PCM_MIN)) begin
            signal_nx = 12'(snd_pkg::PCM_MIN);
        end else begin
            signal_nx = 12'(sum);
        end

        // Step index walk, kept inside the table
        adj     = snd_pkg::INDEX_ADJ[nib[2:0]];
        idx_sum = $signed({2'b00, idx}) + $signed({{3{adj[4]}}, adj});
        if (idx_sum < 0) begin
            idx_nx = '0;
        end else if (idx_sum > 8'(snd_pkg::IDX_MAX)) begin
            idx_nx = 6'(snd_pkg::IDX_MAX);
        end else begin
            idx_nx = 6'(idx_sum);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            signal    <= '0;
            idx       <= '0;
            pcm_valid <= 1'b0;
        end else begin
            pcm_valid <= 1'b0;
            if (clear) begin
                signal <= '0;  // New sample starts from silence
                idx    <= '0;
            end else if (nib_valid) begin
                signal    <= signal_nx;
                idx       <= idx_nx;
                pcm_valid <= 1'b1;
            end
        end
    end

    assign pcm = signal;

endmodule

`default_nettype wire

// ==== snd_mixer.sv ====
/* FM and ADPCM mixer */

`timescale 1ns/1ps
`default_nettype none

module snd_mixer (
    input  logic           clk,
    input  logic           rst,
    input  logic           adpcm_en,
    input  snd_pkg::snd_t  fm_snd,
    input  snd_pkg::pcm_t  pcm,
    input  logic           pcm_valid,
    output snd_pkg::snd_t  snd,
    output logic           sample
);

    logic signed [16:0] mix;  // One guard bit

    // PCM scaled by 4 on top of FM
    assign mix = $signed({fm_snd[15], fm_snd}) + $signed({{3{pcm[11]}}, pcm, 2'b00});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            sample <= 1'b0;
        end else begin
            sample <= pcm_valid;  // Strobe with each new output
            if (pcm_valid) begin
                if (!adpcm_en) begin
                    snd <= fm_snd;  // ADPCM muted
                end else if (mix[16] != mix[15]) begin
                    // Overflow, pin to the rail of the true sign
                    snd <= mix[16] ? 16'sh8000 : 16'sh7fff;
                end else begin
                    snd <= mix[15:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== adpcm_sound.sv ====
/* ADPCM sound branch */

`timescale 1ns/1ps
`default_nettype none

module adpcm_sound (
    input  logic        clk,
    input  logic        rst,
    // Main CPU command
    input  logic        cmd_wr,
    input  logic [7:0]  cmd,
    input  logic        adpcm_en,
    input  logic [15:0] fm_snd,
    // ADPCM ROM
    output logic        rom_req,
    output logic [14:0] rom_addr,
    input  logic [7:0]  rom_data,
    input  logic        rom_ack,
    // Audio out
    output logic [15:0] snd,
    output logic        sample,
    output logic        busy
);

    adpcm_rom_if rom ();

    logic             tick;
    snd_pkg::nibble_t nib;
    logic             nib_valid;
    logic             clear;
    snd_pkg::pcm_t    pcm;
    logic             pcm_valid;

    // ROM pins on the slave side
    assign rom_req  = rom.req;
    assign rom_addr = rom.addr;
    assign rom.ack  = rom_ack;
    assign rom.data = rom_data;

    adpcm_rate_timer u_timer (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    adpcm_seq_fsm u_seq (
        .clk       (clk),
        .rst       (rst),
        .cmd_wr    (cmd_wr),
        .cmd       (cmd),
        .tick      (tick),
        .rom       (rom.master),
        .nib       (nib),
        .nib_valid (nib_valid),
        .clear     (clear),
        .busy      (busy)
    );

    adpcm_decoder u_dec (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .nib       (nib),
        .nib_valid (nib_valid),
        .pcm       (pcm),
        .pcm_valid (pcm_valid)
    );

    snd_mixer u_mix (
        .clk       (clk),
        .rst       (rst),
        .adpcm_en  (adpcm_en),
        .fm_snd    (fm_snd),
        .pcm       (pcm),
        .pcm_valid (pcm_valid),
        .snd       (snd),
        .sample    (sample)
    );

endmodule

`default_nettype wire

// ==== tb_adpcm_sound.sv ====
/* ADPCM sound testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_adpcm_sound;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_wr;
    logic [7:0]  cmd;
    logic        adpcm_en;
    logic [15:0] fm_snd;
    logic        rom_req;
    logic [14:0] rom_addr;
    logic [7:0]  rom_data = 8'h00;
    logic        rom_ack = 1'b0;
    logic [15:0] snd;
    logic        sample;
    logic        busy;

    logic [31:0] lfsr = 32'h572f;
    int          exp_q[$];     // Expected snd per sample pulse
    int          addr_q[$];    // Addresses served by the ROM
    int          errors = 0;
    int          checks = 0;
    int          sample_cnt;
    int          cyc = 0;
    int          last_cyc = -1;
    int          max_gap = 0;  // Widest spacing between samples
    int          ack_base = 0; // Extra ROM latency
    int          rom_state = 0;
    int          rom_wait;
    int          rom_rand;
    bit          timed_out = 1'b0;
    string       test_name = "reset";

    // OKI step sizes
    int step_size [0:48] = '{16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337, 371,
        408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552};

    adpcm_sound DUT (
        .clk(clk), .rst(rst), .cmd_wr(cmd_wr), .cmd(cmd), .adpcm_en(adpcm_en),
        .fm_snd(fm_snd), .rom_req(rom_req), .rom_addr(rom_addr), .rom_data(rom_data),
        .rom_ack(rom_ack), .snd(snd), .sample(sample), .busy(busy)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);  // Galois right shift
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // ROM contents from a hash of the full address
    function automatic logic [7:0] rom_hash(input logic [14:0] a);
        logic [31:0] h;
        h = {17'd0, a} * 32'h9e37_79b1;
        return h[7:0] ^ h[15:8] ^ h[23:16];
    endfunction

    // One OKI code applied to signal and step index
    function automatic void decode_ref(input int code, inout int sig, inout int idx);
        int step;
        int diff;
        step = step_size[idx];
        diff = step / 8;
        if (code & 1) diff += step / 4;
        if (code & 2) diff += step / 2;
        if (code & 4) diff += step;
        if (code & 8) diff = -diff;  // Sign bit
        sig = sig + diff;
        sig = (sig > 2047) ? 2047 : ((sig < -2048) ? -2048 : sig);
        idx = idx + (((code & 7) < 4) ? -1 : 2 * ((code & 7) - 3));
        idx = (idx < 0) ? 0 : ((idx > 48) ? 48 : idx);
    endfunction

    // FM plus PCM times 4 held inside 16 bits
    function automatic int mix_ref(input int fm, input int pcm, input bit en);
        int s;
        s = en ? fm + pcm * 4 : fm;
        return (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
    endfunction

    task automatic compare_value(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // A stuck wait stops the remaining tests
    task automatic note_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout in test %s while waiting for %s", test_name, what);
    endtask

    // ROM model with four-phase handshake and random latency
    always @(negedge clk) begin
        if (rst) begin
            rom_state = 0;
            rom_ack = 1'b0;
        end else begin
            case (rom_state)
                0: if (rom_req && !rom_ack) begin
                    rom_data = rom_hash(rom_addr);  // Data before ack
                    take_bits(3, rom_rand);
                    rom_wait = ack_base + rom_rand;
                    rom_state = 1;
                end
                1: if (rom_wait == 0) begin
                    rom_ack = 1'b1;
                    addr_q.push_back(int'(rom_addr));
                    rom_state = 2;
                end else begin
                    rom_wait--;
                end
                2: if (!rom_req) begin
                    take_bits(3, rom_rand);
                    rom_wait = ack_base + rom_rand;
                    rom_state = 3;
                end
                default: if (rom_wait == 0) begin
                    rom_ack = 1'b0;
                    rom_state = 0;
                end else begin
                    rom_wait--;
                end
            endcase
        end
    end

    // Checks every sample pulse at the falling edge
    always @(negedge clk) begin
        cyc++;
        if (!rst && sample) begin
            if (last_cyc >= 0 && cyc - last_cyc > max_gap) max_gap = cyc - last_cyc;
            last_cyc = cyc;
            sample_cnt++;
            if (exp_q.size() == 0) begin
                report_error({test_name, ": sample pulse with no expected value"});
            end else begin
                compare_value(test_name, exp_q.pop_front(), int'($signed(snd)));
            end
        end
    end

    // Plays one full command and checks its samples and addresses
    task automatic play_cmd(input string name, input logic [7:0] c, input bit en, input int fm,
                            input int stray_at, input logic [7:0] stray_cmd);
        int sig;
        int idx;
        int base;
        int n;
        int err0;
        bit stray_done;
        logic [7:0] b;
        err0 = errors;
        base = int'(c[6:0]) * 256;
        sig = 0;  // Decoder starts from silence
        idx = 0;
        exp_q.delete();
        for (int i = 0; i < 256; i++) begin
            b = rom_hash(15'(base + i));
            decode_ref(int'(b[7:4]), sig, idx);  // High nibble first
            exp_q.push_back(mix_ref(fm, sig, en));
            decode_ref(int'(b[3:0]), sig, idx);
            exp_q.push_back(mix_ref(fm, sig, en));
        end
        addr_q.delete();
        sample_cnt = 0;
        max_gap = 0;
        last_cyc = -1;
        test_name = name;
        stray_done = 1'b0;
        @(negedge clk);
        cmd = c;
        adpcm_en = en;
        fm_snd = 16'(fm);
        cmd_wr = 1'b1;
        @(negedge clk);
        cmd_wr = 1'b0;
        n = 0;
        while (!busy && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            note_timeout("busy to rise");
        end else begin
            n = 0;
            while (busy && n < 100000) begin
                @(negedge clk);
                n++;
                cmd_wr = 1'b0;
                if (stray_at > 0 && !stray_done && sample_cnt >= stray_at) begin
                    cmd = stray_cmd;  // Must be ignored while busy
                    cmd_wr = 1'b1;
                    stray_done = 1'b1;
                end
            end
            cmd_wr = 1'b0;
            if (busy) begin
                note_timeout("busy to fall");
            end else begin
                n = 0;
                while (sample_cnt < 512 && n < 10) begin  // Two-cycle pipeline tail
                    @(negedge clk);
                    n++;
                end
                compare_value({name, " sample count"}, 512, sample_cnt);
                compare_value({name, " address count"}, 256, addr_q.size());
                for (int i = 0; i < addr_q.size() && i < 256; i++) begin
                    compare_value({name, " address"}, base + i, addr_q[i]);
                end
            end
        end
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    initial begin
        rst = 1'b1;
        cmd_wr = 1'b0;
        cmd = 8'h00;
        adpcm_en = 1'b0;
        fm_snd = 16'h0000;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_value("reset busy", 0, int'(busy));
        compare_value("reset rom_req", 0, int'(rom_req));
        compare_value("reset sample", 0, int'(sample));
        compare_value("reset snd", 0, int'($signed(snd)));
        $display("test reset finished with %0d errors", errors);

        play_cmd("cmd_03", 8'h03, 1'b1, 0, 0, 8'h00);
        if (!timed_out) play_cmd("sat_high", 8'h17, 1'b1, 32000, 0, 8'h00);
        if (!timed_out) play_cmd("sat_low", 8'h2c, 1'b1, -32000, 0, 8'h00);
        if (!timed_out) play_cmd("adpcm_off", 8'h05, 1'b0, 1234, 0, 8'h00);
        if (!timed_out) play_cmd("ignored_cmd", 8'h11, 1'b1, -500, 40, 8'h22);
        if (!timed_out) play_cmd("restart", 8'h22, 1'b1, 700, 0, 8'h00);

        ack_base = 28;  // Fetch longer than one tick period
        if (!timed_out) play_cmd("slow_rom", 8'h41, 1'b1, 100, 0, 8'h00);
        ack_base = 0;
        if (!timed_out && max_gap <= 32) begin
            report_error("slow ROM did not stretch the sample spacing");
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
snd_pkg.sv
adpcm_rom_if.sv
adpcm_rate_timer.sv
adpcm_seq_fsm.sv
adpcm_decoder.sv
snd_mixer.sv
adpcm_sound.sv
tb_adpcm_sound.sv

// ==== Makefile ====
# Verilator flow for the ADPCM sound branch

VERILATOR  = verilator
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_adpcm_sound
RTL_TOP    = adpcm_sound
FILELIST   = src.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
